// File: hdl/retire_pkg.sv
////////////////////
// Shared widths, in-flight ID count, op codes
// and write-back unit count for the retire section
////////////////////

`default_nettype none

package retire_pkg;

    // Data path width
    localparam int XLEN = 32;

    // In-flight ID pool
    localparam int MAX_INFLIGHT_COUNT = 8;
    localparam int ID_W = $clog2(MAX_INFLIGHT_COUNT);

    // Register number width
    localparam int RD_W = 5;

    // Units writing back, index 0 ALU, index 1 multiplier
    localparam int NUM_WB_UNITS = 2;

    // Multiplier cycles from accept to done
    localparam int MUL_LATENCY = 3;

    typedef logic [ID_W-1:0] instruction_id_t;

    typedef enum logic [1:0] {
        OP_ADD = 2'b00,
        OP_SUB = 2'b01,
        OP_XOR = 2'b10,
        OP_MUL = 2'b11
    } op_t;

endpackage

`default_nettype wire

// File: hdl/unit_issue_if.sv
////////////////////
// One operation from the issue stage
// to an execution unit
////////////////////

`timescale 1ns/1ps
`default_nettype none

interface unit_issue_if;
    import retire_pkg::*;

    // No ready, units take an op every cycle
    logic valid;
    instruction_id_t id;
    op_t op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;

    modport issuer (output valid, id, op, a, b);

    modport unit (input valid, id, op, a, b);

endinterface

`default_nettype wire

// File: hdl/id_tracking.sv
////////////////////
// Circular in-flight ID allocator
// next, oldest, empty and available
////////////////////

`timescale 1ns/1ps
`default_nettype none

module id_tracking (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic issued,
    input  wire logic retired,
    output retire_pkg::instruction_id_t next_id,
    output retire_pkg::instruction_id_t oldest_id,
    output logic id_available,
    output logic empty
);
    import retire_pkg::*;

    // One extra bit so a full pool is distinct from empty
    logic [ID_W:0] inflight_count;

    ////////////////////
    // Pointers

    // IDs are handed out and retired in the same circular order
    always_ff @(posedge clk) begin
        if (rst) begin
            next_id <= '0;
            oldest_id <= '0;
        end else begin
            if (issued)
                next_id <= next_id + 1'b1;
            if (retired)
                oldest_id <= oldest_id + 1'b1;
        end
    end

    ////////////////////
    // Occupancy

    // Issue and retire in one cycle leave the count as is
    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_count <= '0;
        end else begin
            case ({issued, retired})
                2'b10: inflight_count <= inflight_count + 1'b1;
                2'b01: inflight_count <= inflight_count - 1'b1;
                default: inflight_count <= inflight_count;
            endcase
        end
    end

    // Free ID exists while fewer than eight are out
    assign id_available = inflight_count < (ID_W+1)'(MAX_INFLIGHT_COUNT);

    // Nothing in flight
    assign empty = (inflight_count == '0);

endmodule

`default_nettype wire

// File: hdl/issue_stage.sv
////////////////////
// Issue stage, accepts external ops, takes an ID
// and routes each op to the ALU or multiplier
////////////////////

`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic issue_valid,
    input  wire retire_pkg::op_t issue_op,
    input  wire logic [retire_pkg::XLEN-1:0] issue_a,
    input  wire logic [retire_pkg::XLEN-1:0] issue_b,
    input  wire logic [retire_pkg::RD_W-1:0] issue_rd,
    output logic issue_ready,
    input  wire retire_pkg::instruction_id_t next_id,
    input  wire logic id_available,
    output logic issued,
    output logic [retire_pkg::RD_W-1:0] issued_rd,
    unit_issue_if.issuer alu_if,
    unit_issue_if.issuer mul_if
);
    import retire_pkg::*;

    logic issue_en;
    logic accept;
    logic to_mul;

    // Held low through reset, so no unit sees a valid op then
    always_ff @(posedge clk) begin
        if (rst)
            issue_en <= 1'b0;
        else
            issue_en <= 1'b1;
    end

    ////////////////////
    // Handshake

    // Ready only while a free ID exists
    assign issue_ready = id_available & issue_en;
    assign accept = issue_valid & issue_ready;

    // ID tracking and destination table
    assign issued = accept;
    assign issued_rd = issue_rd;

    ////////////////////
    // Steering

    // Multiply goes to the pipelined unit, all else to the ALU
    assign to_mul = (issue_op == OP_MUL);

    assign alu_if.valid = accept & ~to_mul;
    assign alu_if.id = next_id;
    assign alu_if.op = issue_op;
    assign alu_if.a = issue_a;
    assign alu_if.b = issue_b;

    assign mul_if.valid = accept & to_mul;
    assign mul_if.id = next_id;
    assign mul_if.op = issue_op;
    assign mul_if.a = issue_a;
    assign mul_if.b = issue_b;

endmodule

`default_nettype wire

// File: hdl/alu_unit.sv
////////////////////
// Single-cycle add, sub, xor unit
////////////////////

`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire logic clk,
    input  wire logic rst,
    unit_issue_if.unit issue,
    output logic done,
    output retire_pkg::instruction_id_t id,
    output logic [retire_pkg::XLEN-1:0] rd
);
    import retire_pkg::*;

    logic [XLEN-1:0] result;

    // Op select
    always_comb begin
        case (issue.op)
            OP_ADD: result = issue.a + issue.b;
            OP_SUB: result = issue.a - issue.b;
            // Xor, multiply never steered here
            default: result = issue.a ^ issue.b;
        endcase
    end

    // Completion one cycle after accept
    always_ff @(posedge clk) begin
        if (rst)
            done <= 1'b0;
        else
            done <= issue.valid;
    end

    // Result and its ID
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            id <= issue.id;
            rd <= result;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mul_unit.sv
////////////////////
// Three-stage pipelined multiplier
// low 32 bits of the product, done by ID
////////////////////

`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  wire logic clk,
    input  wire logic rst,
    unit_issue_if.unit issue,
    output logic done,
    output retire_pkg::instruction_id_t id,
    output logic [retire_pkg::XLEN-1:0] rd
);
    import retire_pkg::*;

    // Valid and ID per stage
    logic [MUL_LATENCY-1:0] valid_pipe;
    instruction_id_t id_pipe [MUL_LATENCY];

    // Stage 1 partial products
    logic [XLEN-1:0] pp_ll;
    logic [XLEN/2-1:0] pp_lh;
    logic [XLEN/2-1:0] pp_hl;

    // Stage 2
    logic [XLEN-1:0] s2_ll;
    logic [XLEN/2-1:0] s2_cross;

    ////////////////////
    // Control pipe
    always_ff @(posedge clk) begin
        if (rst)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[MUL_LATENCY-2:0], issue.valid};
    end

    always_ff @(posedge clk) begin
        id_pipe[0] <= issue.id;
        for (int s = 1; s < MUL_LATENCY; s++)
            id_pipe[s] <= id_pipe[s-1];
    end

    ////////////////////
    // Data pipe
    always_ff @(posedge clk) begin
        // Only the low half of each cross term reaches the low word
        pp_ll <= issue.a[XLEN/2-1:0] * issue.b[XLEN/2-1:0];
        pp_lh <= (XLEN/2)'(issue.a[XLEN/2-1:0] * issue.b[XLEN-1:XLEN/2]);
        pp_hl <= (XLEN/2)'(issue.a[XLEN-1:XLEN/2] * issue.b[XLEN/2-1:0]);

        s2_ll <= pp_ll;
        s2_cross <= pp_lh + pp_hl;

        // Cross sum shifted into the upper half
        rd <= s2_ll + {s2_cross, (XLEN/2)'(0)};
    end

    assign done = valid_pipe[MUL_LATENCY-1];
    assign id = id_pipe[MUL_LATENCY-1];

endmodule

`default_nettype wire

// File: hdl/write_back.sv
////////////////////
// Write-back, result slot per ID, done bitmap
// and in-order retire to the register-file port
////////////////////

`timescale 1ns/1ps
`default_nettype none

module write_back (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic issued,
    input  wire logic [retire_pkg::RD_W-1:0] issued_rd,
    input  wire retire_pkg::instruction_id_t next_id,
    input  wire retire_pkg::instruction_id_t oldest_id,
    input  wire logic empty,
    output logic retired,
    input  wire logic unit_done [retire_pkg::NUM_WB_UNITS],
    input  wire retire_pkg::instruction_id_t unit_id [retire_pkg::NUM_WB_UNITS],
    input  wire logic [retire_pkg::XLEN-1:0] unit_rd [retire_pkg::NUM_WB_UNITS],
    output logic retire_valid,
    output retire_pkg::instruction_id_t retire_id,
    output logic [retire_pkg::RD_W-1:0] retire_rd,
    output logic [retire_pkg::XLEN-1:0] retire_data,
    output logic queue_empty
);
    import retire_pkg::*;

    // Destination register per ID
    logic [RD_W-1:0] rd_table [MAX_INFLIGHT_COUNT];

    // Result per ID
    logic [XLEN-1:0] result_slot [MAX_INFLIGHT_COUNT];

    // Done tracking
    logic [MAX_INFLIGHT_COUNT-1:0] id_done_new;
    logic [MAX_INFLIGHT_COUNT-1:0] id_done;
    logic [MAX_INFLIGHT_COUNT-1:0] id_done_r;

    // One-hot of the ID retired, and a cycle later
    logic [MAX_INFLIGHT_COUNT-1:0] retired_onehot;
    logic [MAX_INFLIGHT_COUNT-1:0] retired_onehot_r;

    logic [XLEN-1:0] retire_word;

    ////////////////////
    // Destination table
    always_ff @(posedge clk) begin
        if (issued)
            rd_table[next_id] <= issued_rd;
    end

    ////////////////////
    // Completion

    // Units hold distinct IDs, so at most one hit per ID
    always_comb begin
        for (int i = 0; i < MAX_INFLIGHT_COUNT; i++) begin
            id_done_new[i] = 1'b0;
            for (int j = 0; j < NUM_WB_UNITS; j++) begin
                if (unit_done[j] && (unit_id[j] == ID_W'(i)))
                    id_done_new[i] = 1'b1;
            end
        end
    end

    // Result store, both units may land in one cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < MAX_INFLIGHT_COUNT; i++) begin
            for (int j = 0; j < NUM_WB_UNITS; j++) begin
                if (unit_done[j] && (unit_id[j] == ID_W'(i)))
                    result_slot[i] <= unit_rd[j];
            end
        end
    end

    // Done bit drops the cycle after its ID retires
    assign id_done = (id_done_r & ~retired_onehot_r) | id_done_new;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_done_r <= '0;
            retired_onehot_r <= '0;
        end else begin
            id_done_r <= id_done;
            retired_onehot_r <= retired_onehot;
        end
    end

    ////////////////////
    // Retire

    // Oldest op leaves as soon as it is done, same cycle as its done
    assign retired = id_done[oldest_id] & ~empty;

    always_comb begin
        retired_onehot = '0;
        retired_onehot[oldest_id] = retired;
    end

    // Bypass for a result arriving in the retire cycle
    always_comb begin
        retire_word = result_slot[oldest_id];
        for (int j = 0; j < NUM_WB_UNITS; j++) begin
            if (unit_done[j] && (unit_id[j] == oldest_id))
                retire_word = unit_rd[j];
        end
    end

    // Register-file port, one cycle behind the decision
    always_ff @(posedge clk) begin
        if (rst)
            retire_valid <= 1'b0;
        else
            retire_valid <= retired;
    end

    always_ff @(posedge clk) begin
        retire_id <= oldest_id;
        retire_rd <= rd_table[oldest_id];
        retire_data <= retire_word;
    end

    assign queue_empty = empty;

endmodule

`default_nettype wire

// File: hdl/wb_core.sv
////////////////////
// Top level, issue, units, ID tracking, write-back
////////////////////

`timescale 1ns/1ps
`default_nettype none

module wb_core (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic issue_valid,
    input  wire retire_pkg::op_t issue_op,
    input  wire logic [retire_pkg::XLEN-1:0] issue_a,
    input  wire logic [retire_pkg::XLEN-1:0] issue_b,
    input  wire logic [retire_pkg::RD_W-1:0] issue_rd,
    output logic issue_ready,
    output logic retire_valid,
    output retire_pkg::instruction_id_t retire_id,
    output logic [retire_pkg::RD_W-1:0] retire_rd,
    output logic [retire_pkg::XLEN-1:0] retire_data,
    output logic queue_empty
);
    import retire_pkg::*;

    // ID tracking
    instruction_id_t next_id;
    instruction_id_t oldest_id;
    logic id_available;
    logic empty;
    logic issued;
    logic retired;
    logic [RD_W-1:0] issued_rd;

    // Write-back buses, 0 is the ALU, 1 the multiplier
    wire logic unit_done [NUM_WB_UNITS];
    wire instruction_id_t unit_id [NUM_WB_UNITS];
    wire logic [XLEN-1:0] unit_rd [NUM_WB_UNITS];

    unit_issue_if alu_if ();
    unit_issue_if mul_if ();

    issue_stage issue_stage_inst (
        .clk, .rst,
        .issue_valid, .issue_op, .issue_a, .issue_b, .issue_rd,
        .issue_ready,
        .next_id, .id_available,
        .issued, .issued_rd,
        .alu_if(alu_if.issuer),
        .mul_if(mul_if.issuer)
    );

    id_tracking id_tracking_inst (
        .clk, .rst, .issued, .retired,
        .next_id, .oldest_id, .id_available, .empty
    );

    alu_unit alu_unit_inst (
        .clk, .rst, .issue(alu_if.unit),
        .done(unit_done[0]), .id(unit_id[0]), .rd(unit_rd[0])
    );

    mul_unit mul_unit_inst (
        .clk, .rst, .issue(mul_if.unit),
        .done(unit_done[1]), .id(unit_id[1]), .rd(unit_rd[1])
    );

    write_back write_back_inst (
        .clk, .rst, .issued, .issued_rd, .next_id, .oldest_id, .empty,
        .retired, .unit_done, .unit_id, .unit_rd,
        .retire_valid, .retire_id, .retire_rd, .retire_data, .queue_empty
    );

endmodule

`default_nettype wire

// File: test/wb_core_tb.sv
////////////////////
// Testbench for the retire section, random and directed
// stimulus, scoreboard queue and in-order retire checks
////////////////////

`timescale 1ns/1ps
`default_nettype none

module wb_core_tb;
    import retire_pkg::*;

    localparam int TIMEOUT = 200;

    logic clk = 1'b0;
    logic rst;
    logic issue_valid;
    op_t issue_op;
    logic [XLEN-1:0] issue_a;
    logic [XLEN-1:0] issue_b;
    logic [RD_W-1:0] issue_rd;
    logic issue_ready;
    logic retire_valid;
    instruction_id_t retire_id;
    logic [RD_W-1:0] retire_rd;
    logic [XLEN-1:0] retire_data;
    logic queue_empty;

    // Scoreboard, one entry per accepted op in acceptance order
    logic [XLEN-1:0] exp_data [$];
    logic [RD_W-1:0] exp_rd [$];
    instruction_id_t exp_id [$];
    logic [XLEN-1:0] want_data;
    logic [RD_W-1:0] want_rd;
    instruction_id_t want_id;
    int accept_count = 0;
    logic checks_on = 1'b0;
    logic [31:0] seed = 32'hc8cfedd9;

    wb_core wb_core_inst (
        .clk, .rst, .issue_valid, .issue_op, .issue_a, .issue_b, .issue_rd,
        .issue_ready, .retire_valid, .retire_id, .retire_rd, .retire_data,
        .queue_empty
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Result rule per op, low word for multiply
    function automatic logic [XLEN-1:0] expected_result(input op_t op,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] prod;
        prod = a * b;
        case (op)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_XOR: return a ^ b;
            default: return prod[XLEN-1:0];
        endcase
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s at time %0t", what, $time);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    ////////////////////
    // Stimulus helpers

    // Hold the op until the DUT takes it
    task automatic send_op(input op_t op, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b, input logic [RD_W-1:0] rd);
        int waited;
        waited = 0;
        issue_valid <= 1'b1;
        issue_op <= op;
        issue_a <= a;
        issue_b <= b;
        issue_rd <= rd;
        @(posedge clk);
        while (!issue_ready) begin
            waited++;
            if (waited > TIMEOUT)
                report_timeout("issue_ready");
            @(posedge clk);
        end
        issue_valid <= 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    // Scoreboard drained and DUT reports empty
    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (exp_data.size() != 0 || !queue_empty) begin
            waited++;
            if (waited > TIMEOUT)
                report_timeout("the retire queue to drain");
            @(negedge clk);
        end
    endtask

    ////////////////////
    // Scoreboard

    always @(posedge clk) begin
        if (!rst) begin
            // TB count lags the DUT count, so below eight means a free ID
            if (checks_on)
                assert (issue_ready || exp_data.size() >= MAX_INFLIGHT_COUNT)
                    else report_mismatch("issue_ready low while an ID is free");
            if (issue_valid && issue_ready) begin
                exp_data.push_back(expected_result(issue_op, issue_a, issue_b));
                exp_rd.push_back(issue_rd);
                exp_id.push_back(ID_W'(accept_count));
                accept_count++;
            end
            if (retire_valid) begin
                assert (exp_data.size() != 0)
                    else report_mismatch("retire_valid with no operation outstanding");
                want_data = exp_data.pop_front();
                want_rd = exp_rd.pop_front();
                want_id = exp_id.pop_front();
                assert (retire_data == want_data) else report_mismatch(
                    $sformatf("retire_data %h, expected %h", retire_data, want_data));
                assert (retire_rd == want_rd) else report_mismatch(
                    $sformatf("retire_rd %0d, expected %0d", retire_rd, want_rd));
                assert (retire_id == want_id) else report_mismatch(
                    $sformatf("retire_id %0d, expected %0d", retire_id, want_id));
            end
            assert (exp_data.size() <= MAX_INFLIGHT_COUNT) else report_mismatch(
                $sformatf("%0d operations in flight", exp_data.size()));
        end
    end

    ////////////////////
    // Main sequence

    initial begin
        op_t op;
        logic [RD_W-1:0] rd;
        logic [XLEN-1:0] a;
        int gap;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_op = OP_ADD;
        issue_a = '0;
        issue_b = '0;
        issue_rd = '0;
        idle(16);
        rst <= 1'b0;
        idle(2);
        assert (!retire_valid && issue_ready && queue_empty)
            else report_mismatch("outputs not in reset state after reset");
        checks_on <= 1'b1;

        // Multiply overtaken by ALU ops that finish first
        send_op(OP_MUL, 32'h1234_5678, 32'h9abc_def1, 5'd3);
        send_op(OP_ADD, 32'hffff_fff0, 32'h0000_0020, 5'd4);
        send_op(OP_SUB, 32'h0000_0001, 32'h0000_0002, 5'd5);
        send_op(OP_XOR, 32'ha5a5_a5a5, 32'h0f0f_0f0f, 5'd6);
        wait_drain();
        @(posedge clk);

        // Back-to-back multiply burst
        repeat (24) begin
            seed = xorshift32(seed);
            a = seed;
            seed = xorshift32(seed);
            send_op(OP_MUL, a, seed, seed[4:0]);
        end
        wait_drain();
        @(posedge clk);

        // Random mix with gaps on issue_valid
        repeat (200) begin
            seed = xorshift32(seed);
            op = op_t'(seed[1:0]);
            rd = seed[6:2];
            gap = (seed[9:8] == 2'b00) ? int'(seed[11:10]) + 1 : 0;
            seed = xorshift32(seed);
            a = seed;
            seed = xorshift32(seed);
            send_op(op, a, seed, rd);
            idle(gap);
        end
        wait_drain();

        // Nothing left to retire
        repeat (20) begin
            @(posedge clk);
            assert (!retire_valid && queue_empty)
                else report_mismatch("retire activity after the queue drained");
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hdl/retire_pkg.sv
hdl/unit_issue_if.sv
hdl/id_tracking.sv
hdl/issue_stage.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/write_back.sv
hdl/wb_core.sv
test/wb_core_tb.sv
